// ==== rtl/keyword_dfa.sv ====
`timescale 1ns/1ps

module keyword_dfa #(
  parameter int                       KEYWORD_LEN = 8,
  parameter logic [8*KEYWORD_LEN-1:0] KEYWORD     = "AUTHINFO"
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [7:0]                char_in,
  input  logic                      char_vld,
  input  nntp_rule_pkg::dfa_state_t state_in,
  input  logic                      state_vld,
  output nntp_rule_pkg::dfa_state_t state_out,
  output logic                      accept
);
  import nntp_rule_pkg::*;

  dfa_state_t next_state;
  logic       next_accept;
  logic       last_byte;

  // Keyword byte at a given progress
  // String literals are right aligned, so the first character sits highest
  function automatic logic [7:0] kw_byte(input dfa_state_t idx);
    return KEYWORD[8*(KEYWORD_LEN-1-int'(idx)) +: 8];
  endfunction

  // Current progress points at the final keyword character
  assign last_byte = (state_out == dfa_state_t'(KEYWORD_LEN - 1));

  always_comb
  begin
    next_state  = state_out;
    next_accept = 1'b0;
    // Restored state wins over a character
    if (state_vld)
      next_state = state_in;
    else if (char_vld)
    begin
      if (char_in == kw_byte(state_out))
      begin
        // Full keyword seen, pulse accept and start over
        next_state  = last_byte ? dfa_state_t'(0) : state_out + 1'b1;
        next_accept = last_byte;
      end
      // Mismatch, the byte may still open a new keyword
      else if (char_in == kw_byte(dfa_state_t'(0)))
        next_state = dfa_state_t'(1);
      else
        next_state = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_out <= '0;
      accept    <= 1'b0;
    end
    else
    begin
      state_out <= next_state;
      accept    <= next_accept;
    end
  end

  // Saved progress from the context memory must lie inside the keyword
  assert property (@(posedge clk) disable iff (!rst_n)
    state_vld |-> (state_in < KEYWORD_LEN))
    else $error("keyword_dfa: restored state %0d not below %0d", state_in, KEYWORD_LEN);

  // Restore lands before the first byte of the packet reaches the engine
  assert property (@(posedge clk) disable iff (!rst_n)
    !(state_vld && char_vld))
    else $error("keyword_dfa: state load and character in the same cycle");

endmodule

// ==== rtl/nntp_rule_pkg.sv ====
package nntp_rule_pkg;

  // Stream id width and number of stream slots
  localparam int STREAM_ID_W = 6;
  localparam int NUM_STREAMS = 64;

  // Keyword rules running side by side
  localparam int NUM_RULES = 2;

  // Match progress through a keyword, 0 means nothing matched yet
  typedef logic [3:0] dfa_state_t;

  // One payload byte per cycle
  typedef struct packed {
    logic [7:0] data;
    logic       vld;
    // Marks the last byte of the packet
    logic       eop;
  } char_beat_t;

  // Start of packet strobe with its stream
  typedef struct packed {
    logic                   sop;
    logic [STREAM_ID_W-1:0] stream_id;
  } pkt_ctrl_t;

  // Tracker to rule context, one per rule
  typedef struct packed {
    logic                   load;
    logic                   new_stream;
    logic [STREAM_ID_W-1:0] stream_id;
    logic                   enable;
  } rule_ctx_ctrl_t;

  // Software write of a stream's rule enable mask
  typedef struct packed {
    logic                   wr;
    logic [STREAM_ID_W-1:0] stream_id;
    logic [NUM_RULES-1:0]   mask;
  } cfg_wr_t;

  // Packets that matched a rule
  typedef logic [15:0] rule_count_t;

endpackage

// ==== rtl/nntp_rule_top.sv ====
`timescale 1ns/1ps

module nntp_rule_top #(
  // Rule 0 keyword
  parameter int                    AUTH_LEN     = 8,
  parameter logic [8*AUTH_LEN-1:0] AUTH_KEYWORD = "AUTHINFO",
  // Rule 1 keyword
  parameter int                    XHDR_LEN     = 4,
  parameter logic [8*XHDR_LEN-1:0] XHDR_KEYWORD = "XHDR"
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  nntp_rule_pkg::pkt_ctrl_t                pkt,
  input  nntp_rule_pkg::char_beat_t               beat,
  input  nntp_rule_pkg::cfg_wr_t                  cfg,
  output nntp_rule_pkg::rule_count_t              counts [nntp_rule_pkg::NUM_RULES],
  output logic [nntp_rule_pkg::NUM_RULES-1:0]     fired
);
  import nntp_rule_pkg::*;

  // Per-rule load and context from the tracker
  rule_ctx_ctrl_t ctrl [NUM_RULES];

  // Common aligned beat shared by all rules
  char_beat_t beat_d;

  stream_tracker u_tracker (
    .clk    (clk),
    .rst_n  (rst_n),
    .pkt    (pkt),
    .beat   (beat),
    .cfg    (cfg),
    .ctrl   (ctrl),
    .beat_d (beat_d)
  );

  // AUTHINFO login command
  stream_rule_ctx #(
    .KEYWORD_LEN (AUTH_LEN),
    .KEYWORD     (AUTH_KEYWORD)
  ) u_ctx_authinfo (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl[0]),
    .beat  (beat_d),
    .count (counts[0]),
    .fired (fired[0])
  );

  // XHDR header fetch command
  stream_rule_ctx #(
    .KEYWORD_LEN (XHDR_LEN),
    .KEYWORD     (XHDR_KEYWORD)
  ) u_ctx_xhdr (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl[1]),
    .beat  (beat_d),
    .count (counts[1]),
    .fired (fired[1])
  );

endmodule

// ==== rtl/stream_rule_ctx.sv ====
`timescale 1ns/1ps

module stream_rule_ctx #(
  parameter int                       KEYWORD_LEN = 8,
  parameter logic [8*KEYWORD_LEN-1:0] KEYWORD     = "AUTHINFO"
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  nntp_rule_pkg::rule_ctx_ctrl_t ctrl,
  input  nntp_rule_pkg::char_beat_t     beat,
  output nntp_rule_pkg::rule_count_t    count,
  output logic                          fired
);
  import nntp_rule_pkg::*;

  // Saved progress per stream
  dfa_state_t state_mem [NUM_STREAMS];

  // Packet context latched at load, used again at eop
  logic [STREAM_ID_W-1:0] ctx_id;
  logic                   ctx_en;
  logic                   ctx_new;

  // Restore value for the engine
  dfa_state_t state_in;
  logic       state_in_vld;

  // Boundary registers around the engine
  logic [7:0] char_in_r;
  logic       char_vld_r;
  dfa_state_t state_in_r;
  logic       state_vld_r;
  dfa_state_t state_out;
  logic       accept;
  dfa_state_t state_out_r;
  logic       accept_r;

  // eop follows the byte through tracker, boundary and engine stages
  logic eop_d1;
  logic eop_d2;
  logic eop_d3;

  // Restore strobe and latched context
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_in_vld <= 1'b0;
      ctx_en       <= 1'b0;
      ctx_new      <= 1'b0;
    end
    else
    begin
      state_in_vld <= ctrl.load;
      if (ctrl.load)
      begin
        ctx_en  <= ctrl.enable;
        ctx_new <= ctrl.new_stream;
      end
    end
  end

  // New stream starts from zero, a known one picks up where it left off
  always_ff @(posedge clk)
  begin
    if (ctrl.load)
    begin
      state_in <= ctrl.new_stream ? dfa_state_t'(0) : state_mem[ctrl.stream_id];
      ctx_id   <= ctrl.stream_id;
    end
  end

  // State save at the aligned eop
  always_ff @(posedge clk)
  begin
    if (eop_d3)
    begin
      if (ctx_en)
        state_mem[ctx_id] <= state_out_r;
      // First packet of a disabled stream leaves the slot at its fresh value
      else if (ctx_new)
        state_mem[ctx_id] <= '0;
    end
  end

  // Valid and eop pipeline
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      char_vld_r  <= 1'b0;
      state_vld_r <= 1'b0;
      accept_r    <= 1'b0;
      eop_d1      <= 1'b0;
      eop_d2      <= 1'b0;
      eop_d3      <= 1'b0;
    end
    else
    begin
      char_vld_r  <= beat.vld;
      state_vld_r <= state_in_vld;
      accept_r    <= accept;
      eop_d1      <= beat.vld & beat.eop;
      eop_d2      <= eop_d1;
      eop_d3      <= eop_d2;
    end
  end

  // Boundary data registers
  always_ff @(posedge clk)
  begin
    char_in_r   <= beat.data;
    state_in_r  <= state_in;
    state_out_r <= state_out;
  end

  keyword_dfa #(
    .KEYWORD_LEN (KEYWORD_LEN),
    .KEYWORD     (KEYWORD)
  ) u_dfa (
    .clk       (clk),
    .rst_n     (rst_n),
    .char_in   (char_in_r),
    .char_vld  (char_vld_r),
    .state_in  (state_in_r),
    .state_vld (state_vld_r),
    .state_out (state_out),
    .accept    (accept)
  );

  // Speculative match flag and the packet count
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      count <= '0;
      fired <= 1'b0;
    end
    else
    begin
      if (ctrl.load)
        fired <= 1'b0;
      if (accept_r)
        fired <= 1'b1;
      if (eop_d3)
      begin
        // A match on the last byte has not reached fired yet
        if (ctx_en)
          count <= count + rule_count_t'(fired | accept_r);
        else
          fired <= 1'b0;
      end
    end
  end

  // Context of the previous packet must settle before the next load
  assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.load |-> !(beat.vld && beat.eop) && !eop_d1 && !eop_d2 && !eop_d3)
    else $error("stream_rule_ctx: load while previous eop still pending");

endmodule

// ==== rtl/stream_tracker.sv ====
`timescale 1ns/1ps

module stream_tracker (
  input  logic                          clk,
  input  logic                          rst_n,
  input  nntp_rule_pkg::pkt_ctrl_t      pkt,
  input  nntp_rule_pkg::char_beat_t     beat,
  input  nntp_rule_pkg::cfg_wr_t        cfg,
  output nntp_rule_pkg::rule_ctx_ctrl_t ctrl [nntp_rule_pkg::NUM_RULES],
  output nntp_rule_pkg::char_beat_t     beat_d
);
  import nntp_rule_pkg::*;

  // Streams that already had a packet since reset
  logic [NUM_STREAMS-1:0] seen;

  // Rule enables per stream, written by software
  logic [NUM_RULES-1:0] enable_mask [NUM_STREAMS];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      seen <= '0;
      for (int s = 0; s < NUM_STREAMS; s++)
      begin
        enable_mask[s] <= '0;
      end
    end
    else
    begin
      // Marked after the lookup, so the first packet still sees it as new
      if (pkt.sop)
        seen[pkt.stream_id] <= 1'b1;
      if (cfg.wr)
        enable_mask[cfg.stream_id] <= cfg.mask;
    end
  end

  // Load one cycle after sop, same stream info for every rule
  always_ff @(posedge clk)
  begin
    for (int r = 0; r < NUM_RULES; r++)
    begin
      ctrl[r].new_stream <= !seen[pkt.stream_id];
      ctrl[r].stream_id  <= pkt.stream_id;
      // Each rule gets its own bit of the mask
      ctrl[r].enable     <= enable_mask[pkt.stream_id][r];
      if (!rst_n)
        ctrl[r].load <= 1'b0;
      else
        ctrl[r].load <= pkt.sop;
    end
  end

  // Beats delayed one cycle to line up with the load
  always_ff @(posedge clk)
  begin
    beat_d.data <= beat.data;
    if (!rst_n)
    begin
      beat_d.vld <= 1'b0;
      beat_d.eop <= 1'b0;
    end
    else
    begin
      beat_d.vld <= beat.vld;
      beat_d.eop <= beat.vld & beat.eop;
    end
  end

  // Restore has to reach each engine before the first byte
  assert property (@(posedge clk) disable iff (!rst_n)
    pkt.sop |-> !beat.vld ##1 !beat.vld)
    else $error("stream_tracker: beat within 2 cycles of sop on stream %0d",
                $past(pkt.stream_id));

endmodule

// ==== sim.f ====
+incdir+include
rtl/nntp_rule_pkg.sv
rtl/keyword_dfa.sv
rtl/stream_rule_ctx.sv
rtl/stream_tracker.sv
rtl/nntp_rule_top.sv
tb/tb_nntp_rules.sv

// ==== include/nntp_tb_model.svh ====
`ifndef NNTP_TB_MODEL_SVH
`define NNTP_TB_MODEL_SVH

// Expected per-stream state mirroring the DUT memories
string       m_kw [NUM_RULES] = '{"AUTHINFO", "XHDR"};
int unsigned m_prog [NUM_RULES][NUM_STREAMS];
bit          m_seen [NUM_STREAMS];
bit [NUM_RULES-1:0] m_mask [NUM_STREAMS];
rule_count_t m_count [NUM_RULES];

// Keyword progress after one byte
function automatic int unsigned model_step(input string kw, input int unsigned prog,
                                           input byte unsigned c, inout bit hit);
  if (c == kw[prog])
  begin
    if (prog == kw.len() - 1)
    begin
      hit = 1'b1;
      return 0;
    end
    return prog + 1;
  end
  return (c == kw[0]) ? 1 : 0;
endfunction

function automatic void model_reset();
  foreach (m_prog[r, s])
    m_prog[r][s] = 0;
  foreach (m_seen[s])
    m_seen[s] = 1'b0;
  foreach (m_mask[s])
    m_mask[s] = '0;
  foreach (m_count[r])
    m_count[r] = '0;
endfunction

// Runs one packet and returns fired as it stands after the eop settles
function automatic void model_packet(input int id, input byte unsigned data[$],
                                     output bit [NUM_RULES-1:0] exp_fired);
  int unsigned prog;
  bit          hit;
  for (int r = 0; r < NUM_RULES; r++)
  begin
    prog = m_seen[id] ? m_prog[r][id] : 0;
    hit  = 1'b0;
    foreach (data[i])
      prog = model_step(m_kw[r], prog, data[i], hit);
    exp_fired[r] = hit && m_mask[id][r];
    if (m_mask[id][r])
    begin
      m_prog[r][id] = prog;
      m_count[r]    = m_count[r] + rule_count_t'(hit);
    end
  end
  m_seen[id] = 1'b1;
endfunction

`endif

// ==== tb/tb_nntp_rules.sv ====
`timescale 1ns/1ps

module tb_nntp_rules;
  import nntp_rule_pkg::*;

  `include "nntp_tb_model.svh"

  // Cycles any wait loop may spin before the run gives up
  localparam int WAIT_LIMIT = 2000;

  // Expected results of one packet once its eop has settled
  typedef struct packed {
    logic [NUM_RULES-1:0]        fired;
    rule_count_t [NUM_RULES-1:0] counts;
  } expect_t;

  logic                 clk;
  logic                 rst_n;
  pkt_ctrl_t            pkt;
  char_beat_t           beat;
  cfg_wr_t              cfg;
  rule_count_t          counts [NUM_RULES];
  logic [NUM_RULES-1:0] fired;

  // Stimulus to compare process
  expect_t exp_q [$];
  bit      stim_done;
  bit      cmp_done;
  int      num_checks;
  int      mismatch_errs;
  int      timeout_errs;
  event    abort_run;

  nntp_rule_top UUT (
    .clk    (clk),
    .rst_n  (rst_n),
    .pkt    (pkt),
    .beat   (beat),
    .cfg    (cfg),
    .counts (counts),
    .fired  (fired)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  task automatic report_and_finish();
    $display("Checks %0d, mismatch errors %0d, timeout errors %0d",
             num_checks, mismatch_errs, timeout_errs);
    if (mismatch_errs == 0 && timeout_errs == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic give_up(input string what);
    timeout_errs++;
    $display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
    -> abort_run;
  endtask

  // Ends the run right after a timeout
  initial
  begin
    @(abort_run);
    report_and_finish();
  end

  task automatic check_count(input int rule, input rule_count_t got, input rule_count_t exp);
    num_checks++;
    if (got !== exp)
    begin
      mismatch_errs++;
      $display("Mismatch counts[%0d]: got 0x%h, expected 0x%h at %0t", rule, got, exp, $time);
    end
  endtask

  task automatic check_fired(input logic [NUM_RULES-1:0] got, input logic [NUM_RULES-1:0] exp);
    num_checks++;
    if (got !== exp)
    begin
      mismatch_errs++;
      $display("Mismatch fired: got 0x%h, expected 0x%h at %0t", got, exp, $time);
    end
  endtask

  // Snapshot of the model counts plus the expected fired level
  function automatic void push_expect(input logic [NUM_RULES-1:0] exp_fired);
    expect_t e;
    e.fired = exp_fired;
    for (int r = 0; r < NUM_RULES; r++)
      e.counts[r] = m_count[r];
    exp_q.push_back(e);
  endfunction

  function automatic void add_text(ref byte unsigned data[$], input string s);
    for (int i = 0; i < s.len(); i++)
      data.push_back(s[i]);
  endfunction

  // Mostly keyword letters, so partial matches and restarts are frequent
  function automatic void random_payload(ref byte unsigned data[$]);
    string alphabet;
    string frag;
    int    len;
    int    cut;
    alphabet = "AUTHINFOXDR .-";
    data.delete();
    len = 1 + $urandom_range(7);
    for (int i = 0; i < len; i++)
    begin
      if ($urandom_range(2) == 0)
      begin
        // Whole keyword, a head or a tail of one
        frag = m_kw[$urandom_range(NUM_RULES - 1)];
        cut  = $urandom_range(frag.len() - 1);
        if ($urandom_range(1) == 0)
          frag = frag.substr(0, cut);
        else
          frag = frag.substr(cut, frag.len() - 1);
        add_text(data, frag);
      end
      else
        data.push_back(alphabet[$urandom_range(alphabet.len() - 1)]);
    end
  endfunction

  task automatic write_mask(input int id, input logic [NUM_RULES-1:0] mask);
    @(posedge clk);
    cfg.wr        <= 1'b1;
    cfg.stream_id <= STREAM_ID_W'(id);
    cfg.mask      <= mask;
    @(posedge clk);
    cfg.wr <= 1'b0;
    m_mask[id] = mask;
  endtask

  // sop, at least 2 quiet cycles, then the bytes with optional gaps
  task automatic send_packet(input int id, input byte unsigned data[$], input bit gaps);
    logic [NUM_RULES-1:0] exp_fired;
    int                   gap;
    @(posedge clk);
    pkt.sop       <= 1'b1;
    pkt.stream_id <= STREAM_ID_W'(id);
    @(posedge clk);
    pkt.sop <= 1'b0;
    foreach (data[i])
    begin
      gap = gaps ? $urandom_range(2) : 0;
      repeat (gap)
      begin
        @(posedge clk);
        beat.vld <= 1'b0;
      end
      @(posedge clk);
      beat.data <= data[i];
      beat.vld  <= 1'b1;
      beat.eop  <= (i == data.size() - 1);
    end
    // Expectation goes out on the eop edge
    model_packet(id, data, exp_fired);
    push_expect(exp_fired);
    @(posedge clk);
    beat.vld <= 1'b0;
    beat.eop <= 1'b0;
    // Keeps fired stable until the check and the eop pipeline empty
    repeat (8) @(posedge clk);
  endtask

  // Compare process, samples 5 edges after the eop edge on a falling edge
  initial
  begin : compare_proc
    expect_t e;
    int      waited;
    while (!cmp_done)
    begin
      waited = 0;
      while (exp_q.size() == 0 && !stim_done && waited < WAIT_LIMIT)
      begin
        @(negedge clk);
        waited++;
      end
      if (exp_q.size() != 0)
      begin
        e = exp_q.pop_front();
        repeat (5) @(posedge clk);
        @(negedge clk);
        for (int r = 0; r < NUM_RULES; r++)
          check_count(r, counts[r], e.counts[r]);
        check_fired(fired, e.fired);
      end
      else if (stim_done)
        cmp_done = 1'b1;
      else
      begin
        give_up("next expected packet result");
        cmp_done = 1'b1;
      end
    end
  end

  initial
  begin : main_seq
    byte unsigned data [$];
    int           id;
    int           waited;
    void'($urandom(32'hc296_007d));
    clk   = 1'b0;
    rst_n = 1'b0;
    pkt   = '0;
    beat  = '0;
    cfg   = '0;
    model_reset();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    // Idle after reset
    repeat (3) @(posedge clk);
    push_expect('0);
    repeat (8) @(posedge clk);

    // Keyword twice, then a packet with none
    write_mask(1, 2'b11);
    data.delete();
    add_text(data, "x AUTHINFO user XHDR 12 AUTHINFO");
    send_packet(1, data, 1'b0);
    data.delete();
    add_text(data, "GROUP misc");
    send_packet(1, data, 1'b1);

    // Split over packets of one stream
    data.delete();
    add_text(data, "list AUTH");
    send_packet(1, data, 1'b1);
    data.delete();
    add_text(data, "INFO ok XH");
    send_packet(1, data, 1'b0);
    data.delete();
    add_text(data, "DR");
    send_packet(1, data, 1'b1);

    // Second half lands on a stream never seen
    write_mask(2, 2'b11);
    write_mask(3, 2'b11);
    data.delete();
    add_text(data, "user AUTH");
    send_packet(2, data, 1'b0);
    data.delete();
    add_text(data, "INFO");
    send_packet(3, data, 1'b0);

    // Rule 0 off in the middle packet keeps its saved progress
    write_mask(4, 2'b11);
    data.delete();
    add_text(data, "AUTHI");
    send_packet(4, data, 1'b0);
    write_mask(4, 2'b10);
    data.delete();
    add_text(data, "NFO XHDR");
    send_packet(4, data, 1'b1);
    write_mask(4, 2'b11);
    data.delete();
    add_text(data, "NFO");
    send_packet(4, data, 1'b0);

    // Random streams, masks and gaps
    for (int p = 0; p < 40; p++)
    begin
      if ($urandom_range(3) == 0)
        write_mask($urandom_range(11), NUM_RULES'($urandom));
      if (p % 8 == 7)
        id = 16 + $urandom_range(47);
      else
        id = $urandom_range(11);
      random_payload(data);
      send_packet(id, data, 1'b1);
    end

    repeat (2) @(posedge clk);
    stim_done = 1'b1;
    waited    = 0;
    while (!cmp_done && waited < WAIT_LIMIT)
    begin
      @(posedge clk);
      waited++;
    end
    if (!cmp_done)
      give_up("compare process completion");
    else
      report_and_finish();
  end

endmodule
